//--- src/forthCore_params.svh
`ifndef FORTH_CORE_PARAMS_SVH
`define FORTH_CORE_PARAMS_SVH

// Data and address words share one width
`define FORTH_DATA_WIDTH 16

// R0 to R6 plus RA at the top index
`define FORTH_REG_COUNT 8

`define FORTH_RESET_PC 16'h0000

`endif

//--- src/isaPkg.sv
`default_nettype none

package isaPkg;

	// Top four bits of every instruction
	typedef enum logic [3:0] {
		arithmeticLogic = 4'h1,
		loadStore       = 4'h2
	} instrGroupT;

	// Only the move survives in this core
	typedef enum logic [1:0] {
		aluMov = 2'b00
	} aluOpT;

	typedef enum logic [1:0] {
		regAS8 = 2'b00,
		regAU8 = 2'b01,
		regU4  = 2'b10
	} aluModeT;

	typedef enum logic [1:0] {
		ld  = 2'b00,
		st  = 2'b01,
		ldb = 2'b10,
		stb = 2'b11
	} ldsOpT;

	// Post-increment and post-decrement step the base after the access
	typedef enum logic [1:0] {
		regReg    = 2'b00,
		regRegInc = 2'b01,
		regRegDec = 2'b10,
		here      = 2'b11
	} ldsModeT;

	// For regU4 the upper nibble of imm names the target register
	typedef struct packed {
		instrGroupT grp;
		aluOpT      op;
		aluModeT    mode;
		logic [7:0] imm;
	} aluInstrT;

	typedef struct packed {
		instrGroupT grp;
		logic [1:0] rsvd;
		ldsOpT      op;
		ldsModeT    mode;
		logic [2:0] dataReg;
		logic [2:0] baseReg;
	} ldsInstrT;

	typedef union packed {
		aluInstrT    alu;
		ldsInstrT    lds;
		logic [15:0] raw;
	} instrT;

endpackage

`default_nettype wire

//--- src/corePkg.sv
`default_nettype none
`include "forthCore_params.svh"

package corePkg;

	typedef enum logic [1:0] {
		fetchPh   = 2'b00,
		decodePh  = 2'b01,
		executePh = 2'b10,
		commitPh  = 2'b11
	} phaseT;

	typedef logic [$clog2(`FORTH_REG_COUNT)-1:0] regIdxT;

	typedef logic [`FORTH_DATA_WIDTH-1:0] wordT;

	// For stores dst names the register whose value goes out
	typedef struct packed {
		logic            isMove;
		logic            isLoad;
		logic            isStore;
		logic            isByte;
		logic            isHere;
		isaPkg::ldsModeT mode;
		regIdxT          dst;
		regIdxT          base;
		wordT            imm;
	} decodedT;

endpackage

`default_nettype wire

//--- src/memAccessIf.sv
`timescale 1ns/10ps
`default_nettype none

interface memAccessIf (
	input logic CLK
);
	import corePkg::*;

	logic       req;
	logic       write;
	wordT       addr;
	wordT       wdata;
	logic [1:0] laneMask;
	wordT       rdata;

	// Read data comes back in the request cycle
	modport requester (
		output req, write, addr, wdata, laneMask,
		input  rdata
	);

	modport responder (
		input  CLK, req, write, addr, wdata, laneMask,
		output rdata
	);

endinterface

`default_nettype wire

//--- src/coreSequencer.sv
`timescale 1ns/10ps
`default_nettype none
`include "forthCore_params.svh"

module coreSequencer (
	input  logic             CLK,
	input  logic             rstN,
	input  corePkg::decodedT dec,
	output corePkg::phaseT   phase,
	output isaPkg::instrT    instr,
	output corePkg::wordT    pc,
	memAccessIf.requester    fetchAcc
);
	import corePkg::*;

	// Held low until the first edge after reset is released
	logic  running;
	phaseT nextPhase;
	wordT  pcStep;

	always_comb begin
		case (phase)
			fetchPh:   nextPhase = decodePh;
			decodePh:  nextPhase = executePh;
			executePh: nextPhase = commitPh;
			default:   nextPhase = fetchPh;
		endcase
	end

	// A here load skips its inline operand word
	assign pcStep = dec.isHere ? wordT'(4) : wordT'(2);

	always_ff @(posedge CLK or negedge rstN) begin
		if (!rstN) begin
			running <= 1'b0;
			phase   <= fetchPh;
			pc      <= `FORTH_RESET_PC;
		end else begin
			running <= 1'b1;
			if (running) begin
				phase <= nextPhase;
				if (phase == commitPh)
					pc <= pc + pcStep;
			end
		end
	end

	// Instruction register
	always_ff @(posedge CLK) begin
		if (fetchAcc.req)
			instr <= fetchAcc.rdata;
	end

	assign fetchAcc.req      = running && (phase == fetchPh);
	assign fetchAcc.write    = 1'b0;
	assign fetchAcc.addr     = pc;
	assign fetchAcc.wdata    = '0;
	assign fetchAcc.laneMask = 2'b11;

	// Phase encodings count up by one and wrap after commit
	assert property (@(posedge CLK) disable iff (!rstN)
		running |=> phase == phaseT'($past(phase) + 2'd1))
		else $error("Phase sequence broken");

	// One fetch per instruction, then three quiet cycles
	assert property (@(posedge CLK) disable iff (!rstN)
		fetchAcc.req |-> (phase == fetchPh) ##1 !fetchAcc.req [*3] ##1 fetchAcc.req)
		else $error("Fetch request outside its slot");

endmodule

`default_nettype wire

//--- src/instructionDecoder.sv
`timescale 1ns/10ps
`default_nettype none
`include "forthCore_params.svh"

module instructionDecoder (
	input  isaPkg::instrT    instr,
	output corePkg::decodedT dec
);
	import isaPkg::*;
	import corePkg::*;

	localparam regIdxT raIdx = regIdxT'(`FORTH_REG_COUNT - 1);

	always_comb begin
		// Anything not matched below falls through as a no-op
		dec = '0;
		case (instr.alu.grp)
			arithmeticLogic: begin
				if (instr.alu.op == aluMov) begin
					case (instr.alu.mode)
						regAS8: begin
							dec.isMove = 1'b1;
							dec.dst    = raIdx;
							dec.imm    = {{(`FORTH_DATA_WIDTH-8){instr.alu.imm[7]}},
								instr.alu.imm};
						end
						regAU8: begin
							dec.isMove = 1'b1;
							dec.dst    = raIdx;
							dec.imm    = {{(`FORTH_DATA_WIDTH-8){1'b0}}, instr.alu.imm};
						end
						regU4: begin
							// RA is reached only through the 8-bit modes
							if (instr.alu.imm[7:4] < 4'(`FORTH_REG_COUNT - 1)) begin
								dec.isMove = 1'b1;
								dec.dst    = regIdxT'(instr.alu.imm[7:4]);
								dec.imm    = {{(`FORTH_DATA_WIDTH-4){1'b0}}, instr.alu.imm[3:0]};
							end
						end
						default: ;
					endcase
				end
			end
			loadStore: begin
				if (instr.lds.rsvd == 2'b00) begin
					dec.mode = instr.lds.mode;
					dec.dst  = instr.lds.dataReg;
					dec.base = instr.lds.baseReg;
					if (instr.lds.mode == here) begin
						// Inline operand only makes sense as a word load
						if (instr.lds.op == ld) begin
							dec.isLoad = 1'b1;
							dec.isHere = 1'b1;
						end
					end else begin
						dec.isLoad  = (instr.lds.op == ld) || (instr.lds.op == ldb);
						dec.isStore = (instr.lds.op == st) || (instr.lds.op == stb);
						dec.isByte  = (instr.lds.op == ldb) || (instr.lds.op == stb);
					end
				end
			end
			default: ;
		endcase
	end

endmodule

`default_nettype wire

//--- src/registerFile.sv
`timescale 1ns/10ps
`default_nettype none
`include "forthCore_params.svh"

module registerFile (
	input  logic            CLK,
	input  logic            rstN,
	input  corePkg::regIdxT rdIdxA,
	input  corePkg::regIdxT rdIdxB,
	output corePkg::wordT   rdDataA,
	output corePkg::wordT   rdDataB,
	input  logic            wrEn,
	input  corePkg::regIdxT wrIdx,
	input  corePkg::wordT   wrData,
	input  logic            baseEn,
	input  corePkg::regIdxT baseIdx,
	input  corePkg::wordT   baseData
);
	import corePkg::*;

	wordT regs [`FORTH_REG_COUNT];

	always_ff @(posedge CLK or negedge rstN) begin
		if (!rstN) begin
			for (int i = 0; i < `FORTH_REG_COUNT; i++)
				regs[i] <= '0;
		end else begin
			if (baseEn)
				regs[baseIdx] <= baseData;
			// Data write wins, e.g. a pop into its own base
			if (wrEn)
				regs[wrIdx] <= wrData;
		end
	end

	assign rdDataA = regs[rdIdxA];
	assign rdDataB = regs[rdIdxB];

	assert property (@(posedge CLK) disable iff (!rstN)
		(wrEn |-> !$isunknown(wrIdx)) and (baseEn |-> !$isunknown(baseIdx)))
		else $error("Register write index unknown");

endmodule

`default_nettype wire

//--- src/loadStoreUnit.sv
`timescale 1ns/10ps
`default_nettype none
`include "forthCore_params.svh"

module loadStoreUnit (
	input  logic             CLK,
	input  logic             rstN,
	input  corePkg::phaseT   phase,
	input  corePkg::decodedT dec,
	input  corePkg::wordT    pc,
	input  corePkg::wordT    baseVal,
	input  corePkg::wordT    dataVal,
	output corePkg::wordT    loadData,
	output corePkg::wordT    nextBase,
	memAccessIf.requester    dataAcc
);
	import isaPkg::*;
	import corePkg::*;

	logic       hiLane;
	logic [7:0] laneByte;
	wordT       step;

	// Here loads read the word right after the instruction
	assign dataAcc.addr  = dec.isHere ? pc + wordT'(2) : baseVal;
	assign dataAcc.req   = (phase == executePh) && (dec.isLoad || dec.isStore);
	assign dataAcc.write = dec.isStore;

	// Odd byte address lands on the high lane
	assign hiLane = dataAcc.addr[0];

	always_comb begin
		if (!dec.isByte)
			dataAcc.laneMask = 2'b11;
		else if (hiLane)
			dataAcc.laneMask = 2'b10;
		else
			dataAcc.laneMask = 2'b01;
	end

	always_comb begin
		if (!dec.isByte)
			dataAcc.wdata = dataVal;
		else if (hiLane)
			dataAcc.wdata = {dataVal[7:0], 8'h00};
		else
			dataAcc.wdata = {8'h00, dataVal[7:0]};
	end

	assign laneByte = hiLane ? dataAcc.rdata[15:8] : dataAcc.rdata[7:0];

	always_ff @(posedge CLK or negedge rstN) begin
		if (!rstN)
			loadData <= '0;
		else if (dataAcc.req && !dataAcc.write)
			loadData <= dec.isByte ? {{(`FORTH_DATA_WIDTH-8){1'b0}}, laneByte}
				: dataAcc.rdata;
	end

	// Base moves by the access size
	assign step = dec.isByte ? wordT'(1) : wordT'(2);

	always_comb begin
		case (dec.mode)
			regRegInc: nextBase = baseVal + step;
			regRegDec: nextBase = baseVal - step;
			default:   nextBase = baseVal;
		endcase
	end

	assert property (@(posedge CLK) disable iff (!rstN)
		dataAcc.req |-> (dataAcc.laneMask != 2'b00) ##1 !dataAcc.req)
		else $error("Data request without lanes or longer than one cycle");

endmodule

`default_nettype wire

//--- src/busInterface.sv
`timescale 1ns/10ps
`default_nettype none

module busInterface (
	memAccessIf.responder fetchAcc,
	memAccessIf.responder dataAcc,
	output corePkg::wordT addrBuf,
	output corePkg::wordT doutBuf,
	input  corePkg::wordT din,
	output logic          rdN,
	output logic          wrN0,
	output logic          wrN1,
	output logic          abusOeN
);
	import corePkg::*;

	logic       req;
	logic       write;
	logic [1:0] laneMask;

	// Data access owns the bus in execute, fetch otherwise
	assign req      = fetchAcc.req || dataAcc.req;
	assign write    = dataAcc.req ? dataAcc.write : fetchAcc.write;
	assign laneMask = dataAcc.req ? dataAcc.laneMask : fetchAcc.laneMask;
	assign addrBuf  = dataAcc.req ? dataAcc.addr : fetchAcc.addr;

	always_comb begin
		if (dataAcc.req && dataAcc.write)
			doutBuf = dataAcc.wdata;
		else if (fetchAcc.req && fetchAcc.write)
			doutBuf = fetchAcc.wdata;
		else
			doutBuf = '0;
	end

	// Strobes are active low
	assign rdN     = !(req && !write);
	assign wrN0    = !(req && write && laneMask[0]);
	assign wrN1    = !(req && write && laneMask[1]);
	assign abusOeN = !req;

	assign fetchAcc.rdata = din;
	assign dataAcc.rdata  = din;

	assert property (@(posedge fetchAcc.CLK) !(fetchAcc.req && dataAcc.req))
		else $error("Fetch and data requests collide");

endmodule

`default_nettype wire

//--- src/core.sv
`timescale 1ns/10ps
`default_nettype none
`include "forthCore_params.svh"

module core (
	input  logic                         CLK,
	input  logic                         rstN,
	output logic                         fetch,
	output logic                         decode,
	output logic                         execute,
	output logic                         commit,
	output logic [`FORTH_DATA_WIDTH-1:0] addrBuf,
	output logic [`FORTH_DATA_WIDTH-1:0] doutBuf,
	input  logic [`FORTH_DATA_WIDTH-1:0] din,
	output logic                         rdN,
	output logic                         wrN0,
	output logic                         wrN1,
	output logic                         abusOeN
);
	import isaPkg::*;
	import corePkg::*;

	phaseT   phase;
	instrT   instr;
	wordT    pc;
	decodedT dec;
	wordT    baseVal;
	wordT    dataVal;
	wordT    loadData;
	wordT    nextBase;
	logic    wrEn;
	logic    baseEn;
	wordT    wrData;

	memAccessIf fetchAcc (.CLK(CLK));
	memAccessIf dataAcc (.CLK(CLK));

	coreSequencer sequencer_inst (
		.CLK      (CLK),
		.rstN     (rstN),
		.dec      (dec),
		.phase    (phase),
		.instr    (instr),
		.pc       (pc),
		.fetchAcc (fetchAcc.requester)
	);

	instructionDecoder decoder_inst (
		.instr (instr),
		.dec   (dec)
	);

	// All architectural updates land at the end of commit
	assign wrEn   = (phase == commitPh) && (dec.isMove || dec.isLoad);
	assign baseEn = (phase == commitPh) && (dec.isLoad || dec.isStore) && !dec.isHere
		&& ((dec.mode == regRegInc) || (dec.mode == regRegDec));
	assign wrData = dec.isMove ? dec.imm : loadData;

	registerFile regFile_inst (
		.CLK      (CLK),
		.rstN     (rstN),
		.rdIdxA   (dec.base),
		.rdIdxB   (dec.dst),
		.rdDataA  (baseVal),
		.rdDataB  (dataVal),
		.wrEn     (wrEn),
		.wrIdx    (dec.dst),
		.wrData   (wrData),
		.baseEn   (baseEn),
		.baseIdx  (dec.base),
		.baseData (nextBase)
	);

	loadStoreUnit lsu_inst (
		.CLK      (CLK),
		.rstN     (rstN),
		.phase    (phase),
		.dec      (dec),
		.pc       (pc),
		.baseVal  (baseVal),
		.dataVal  (dataVal),
		.loadData (loadData),
		.nextBase (nextBase),
		.dataAcc  (dataAcc.requester)
	);

	busInterface bus_inst (
		.fetchAcc (fetchAcc.responder),
		.dataAcc  (dataAcc.responder),
		.addrBuf  (addrBuf),
		.doutBuf  (doutBuf),
		.din      (din),
		.rdN      (rdN),
		.wrN0     (wrN0),
		.wrN1     (wrN1),
		.abusOeN  (abusOeN)
	);

	// Fetch request already stays low until the core starts running
	assign fetch   = fetchAcc.req;
	assign decode  = (phase == decodePh);
	assign execute = (phase == executePh);
	assign commit  = (phase == commitPh);

endmodule

`default_nettype wire

//--- testbench/coreRefModel.sv
`timescale 1ns/10ps
`default_nettype none
`include "forthCore_params.svh"

module coreRefModel;

	logic [15:0] regs [8];
	logic        movedReg [8];
	logic [15:0] pc;
	logic [15:0] mem [32768];

	// Prediction for the instruction in flight
	logic        isMove;
	logic [2:0]  moveDst;
	logic [15:0] moveVal;
	logic        accValid;
	logic        accWrite;
	logic        accByte;
	logic [15:0] accAddr;
	logic [1:0]  accLanes;
	logic [15:0] accData;

	task automatic resetState();
		for (int i = 0; i < 8; i++) begin
			regs[i] = 16'h0000;
			movedReg[i] = 1'b0;
		end
		pc = `FORTH_RESET_PC;
	endtask

	task automatic predict(input logic [15:0] iw);
		logic [15:0] src;
		isMove = 1'b0;
		accValid = 1'b0;
		accWrite = iw[8];
		accByte = iw[9];
		src = regs[iw[5:3]];
		if (iw[15:12] == 4'h1 && iw[11:10] == 2'b00) begin
			// U4 reaches R0 to R6 only
			isMove = (iw[9:8] != 2'b11) && !(iw[9:8] == 2'b10 && iw[7:4] >= 4'd7);
			moveDst = (iw[9:8] == 2'b10) ? iw[6:4] : 3'd7;
			case (iw[9:8])
				2'b00: moveVal = {{8{iw[7]}}, iw[7:0]};
				2'b01: moveVal = {8'h00, iw[7:0]};
				default: moveVal = {12'h000, iw[3:0]};
			endcase
		end else if (iw[15:12] == 4'h2 && iw[11:10] == 2'b00) begin
			if (iw[7:6] == 2'b11) begin
				// Here load reads the word after the instruction
				accValid = (iw[9:8] == 2'b00);
				accAddr = pc + 16'd2;
			end else begin
				accValid = 1'b1;
				accAddr = regs[iw[2:0]];
			end
			accLanes = !accByte ? 2'b11 : (accAddr[0] ? 2'b10 : 2'b01);
			accData = !accByte ? src : (accAddr[0] ? {src[7:0], 8'h00} : {8'h00, src[7:0]});
		end
	endtask

	task automatic retire(input logic [15:0] iw);
		logic [15:0] word;
		logic [15:0] step;
		step = accByte ? 16'd1 : 16'd2;
		if (isMove) begin
			regs[moveDst] = moveVal;
			movedReg[moveDst] = 1'b1;
		end else if (accValid) begin
			word = mem[accAddr[15:1]];
			// Base moves first so that a load into the base wins
			if (iw[7:6] == 2'b01)
				regs[iw[2:0]] = regs[iw[2:0]] + step;
			else if (iw[7:6] == 2'b10)
				regs[iw[2:0]] = regs[iw[2:0]] - step;
			if (accWrite) begin
				if (accLanes[0])
					mem[accAddr[15:1]][7:0] = accData[7:0];
				if (accLanes[1])
					mem[accAddr[15:1]][15:8] = accData[15:8];
			end else begin
				regs[iw[5:3]] = !accByte ? word
					: {8'h00, accAddr[0] ? word[15:8] : word[7:0]};
				movedReg[iw[5:3]] = 1'b0;
			end
		end
		pc = pc + ((accValid && iw[7:6] == 2'b11) ? 16'd4 : 16'd2);
	endtask

endmodule

`default_nettype wire

//--- testbench/coreTb.sv
`timescale 1ns/10ps
`default_nettype none

module coreTb;

	localparam int progLen = 200;
	localparam int cycleLimit = 4 * progLen + 50;

	localparam int resetTest = 0;
	localparam int phaseTest = 1;
	localparam int moveTest = 2;
	localparam int wordTest = 3;
	localparam int byteTest = 4;
	localparam int unknownTest = 5;

	logic        CLK;
	logic        rstN;
	logic        fetch;
	logic        decode;
	logic        execute;
	logic        commit;
	logic [15:0] addrBuf;
	logic [15:0] doutBuf;
	logic [15:0] din;
	logic        rdN;
	logic        wrN0;
	logic        wrN1;
	logic        abusOeN;

	logic [15:0] mem [32768];
	logic [31:0] seed;
	int          progTop;
	int          cycles;
	int          checks [6];
	int          errors [6];

	core core_inst (
		.CLK     (CLK),
		.rstN    (rstN),
		.fetch   (fetch),
		.decode  (decode),
		.execute (execute),
		.commit  (commit),
		.addrBuf (addrBuf),
		.doutBuf (doutBuf),
		.din     (din),
		.rdN     (rdN),
		.wrN0    (wrN0),
		.wrN1    (wrN1),
		.abusOeN (abusOeN)
	);

	coreRefModel model_inst ();

	initial begin
		CLK = 1'b0;
		forever #10 CLK = ~CLK;
	end

	// Memory answers reads and takes lane writes in mid-cycle
	always @(negedge CLK) begin
		if (!wrN0)
			mem[addrBuf[15:1]][7:0] = doutBuf[7:0];
		if (!wrN1)
			mem[addrBuf[15:1]][15:8] = doutBuf[15:8];
		din <= rdN ? 16'h0000 : mem[addrBuf[15:1]];
	end

	initial begin
		cycles = 0;
		while (cycles < cycleLimit) begin
			@(posedge CLK);
			cycles++;
		end
		$display("Timeout: run did not finish within %0d cycles", cycleLimit);
		$display("Checks failed");
		$finish;
	end

	function automatic logic [31:0] nextRandom();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed;
	endfunction

	function automatic string testLabel(input int t);
		case (t)
			resetTest: return "reset";
			phaseTest: return "phase order";
			moveTest: return "moves";
			wordTest: return "word access";
			byteTest: return "byte access";
			default: return "unknown encodings";
		endcase
	endfunction

	task automatic checkValue(input int t, input string what, input logic [15:0] expected,
		input logic [15:0] actual);
		checks[t]++;
		assert (actual === expected)
		else begin
			errors[t]++;
			$display("CHECK FAILED %s, %s: expected %h, actual %h",
				testLabel(t), what, expected, actual);
		end
	endtask

	task automatic checkIdle(input int t, input string what);
		checkValue(t, what, 16'h000F, {rdN, wrN1, wrN0, abusOeN});
	endtask

	task automatic reportTest(input int t);
		$display("%s: %0d checks, %0d errors", testLabel(t), checks[t], errors[t]);
	endtask

	task automatic emit(input logic [15:0] w);
		mem[progTop] = w;
		model_inst.mem[progTop] = w;
		progTop++;
	endtask

	// R0 to R3 and RA hold data, R4 to R6 serve as bases
	function automatic logic [2:0] dataReg(input logic [2:0] r);
		return r[2] ? 3'd7 : r;
	endfunction

	function automatic logic [2:0] baseReg(input logic [1:0] r);
		return (r == 2'd3) ? 3'd4 : 3'd4 + r;
	endfunction

	function automatic logic [1:0] addrMode(input logic [1:0] r);
		return (r == 2'b11) ? 2'b00 : r;
	endfunction

	// Each of these decodes as a no-op
	function automatic logic [15:0] unknownEncoding(input logic [31:0] r);
		case (r[2:0])
			3'd0: return {4'h0, r[27:16]};
			3'd1: return {4'h9, r[27:16]};
			3'd2: return {4'h1, 1'b1, r[26:16]};
			3'd3: return {4'h1, 4'b0011, r[23:16]};
			3'd4: return {4'h1, 4'b0010, 1'b1, r[22:16]};
			3'd5: return {4'h2, 2'b01, r[25:16]};
			3'd6: return {4'h2, 2'b00, r[21], 1'b1, 2'b11, r[20:15]};
			default: return {4'h7, r[27:16]};
		endcase
	endfunction

	task automatic emitHereLoad(input logic [2:0] dst, input logic [15:0] value);
		emit({4'h2, 2'b00, 2'b00, 2'b11, dst, 3'b000});
		// Bases stay in a data window well above the program
		emit((dst >= 3'd4 && dst <= 3'd6) ? {4'h8, value[11:0]} : value);
	endtask

	task automatic buildProgram();
		logic [31:0] r;
		for (int i = 0; i < 32768; i++) begin
			mem[i] = 16'(i * 40503) ^ 16'h5aa5;
			model_inst.mem[i] = mem[i];
		end
		progTop = 0;
		for (int b = 4; b < 7; b++) begin
			r = nextRandom();
			emitHereLoad(3'(b), r[15:0]);
		end
		for (int n = 3; n < progLen; n++) begin
			r = nextRandom();
			case (r[31:28])
				4'd0: emit({4'h1, 2'b00, 1'b0, r[27], r[7:0]});
				4'd1, 4'd2: emit({4'h1, 4'b0010, 2'b00, r[9:8], r[3:0]});
				4'd3, 4'd4, 4'd5, 4'd6: emit({4'h2, 2'b00, 1'b0, r[20], addrMode(r[19:18]),
					dataReg(r[14:12]), baseReg(r[17:16])});
				4'd7, 4'd8, 4'd9, 4'd10: emit({4'h2, 2'b00, 1'b1, r[20], addrMode(r[19:18]),
					dataReg(r[14:12]), baseReg(r[17:16])});
				4'd11, 4'd12: emitHereLoad(r[5:3], r[27:12]);
				default: emit(unknownEncoding(r));
			endcase
		end
	endtask

	// Steps through the four phases, starting at a fetch
	task automatic runInstruction();
		logic [15:0] iw;
		int accTest;
		checkValue(phaseTest, "fetch phase", 16'h0008, {fetch, decode, execute, commit});
		checkValue(phaseTest, "fetch address", model_inst.pc, addrBuf);
		checkValue(phaseTest, "fetch strobes", 16'h0006, {rdN, wrN1, wrN0, abusOeN});
		iw = model_inst.mem[model_inst.pc[15:1]];
		model_inst.predict(iw);
		if (model_inst.isMove)
			accTest = moveTest;
		else if (!model_inst.accValid)
			accTest = unknownTest;
		else
			accTest = model_inst.accByte ? byteTest : wordTest;
		@(negedge CLK);
		checkValue(phaseTest, "decode phase", 16'h0004, {fetch, decode, execute, commit});
		checkIdle(phaseTest, "decode strobes");
		@(negedge CLK);
		checkValue(phaseTest, "execute phase", 16'h0002, {fetch, decode, execute, commit});
		if (model_inst.accValid) begin
			checkValue(accTest, "access address", model_inst.accAddr, addrBuf);
			checkValue(accTest, "access strobes", {12'h000, model_inst.accWrite,
				!(model_inst.accWrite && model_inst.accLanes[1]),
				!(model_inst.accWrite && model_inst.accLanes[0]), 1'b0},
				{rdN, wrN1, wrN0, abusOeN});
			if (model_inst.accWrite)
				checkValue(model_inst.movedReg[iw[5:3]] ? moveTest : accTest, "store data",
					model_inst.accData, doutBuf);
		end else begin
			checkIdle(accTest, "execute strobes");
		end
		@(negedge CLK);
		checkValue(phaseTest, "commit phase", 16'h0001, {fetch, decode, execute, commit});
		checkIdle(accTest, "commit strobes");
		model_inst.retire(iw);
	endtask

	initial begin
		int total;
		int failed;
		rstN = 1'b0;
		din = 16'h0000;
		seed = 32'h5c9d_e3fb;
		for (int t = 0; t < 6; t++) begin
			checks[t] = 0;
			errors[t] = 0;
		end
		buildProgram();
		model_inst.resetState();
		repeat (2) begin
			@(negedge CLK);
			checkIdle(resetTest, "strobes in reset");
			checkValue(resetTest, "phases in reset", 16'h0000, {fetch, decode, execute, commit});
		end
		rstN = 1'b1;
		@(negedge CLK);
		checkValue(resetTest, "first fetch", 16'h0001, {15'h0000, fetch});
		checkValue(resetTest, "first fetch address", 16'h0000, addrBuf);
		reportTest(resetTest);
		for (int n = 0; n < progLen; n++) begin
			runInstruction();
			@(negedge CLK);
		end
		total = 0;
		failed = 0;
		for (int t = 0; t < 6; t++) begin
			if (t != resetTest)
				reportTest(t);
			total += checks[t];
			failed += errors[t];
		end
		$display("Total: %0d checks, %0d failed", total, failed);
		if (failed == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- forthCore.f
+incdir+src
src/isaPkg.sv
src/corePkg.sv
src/memAccessIf.sv
src/coreSequencer.sv
src/instructionDecoder.sv
src/registerFile.sv
src/loadStoreUnit.sv
src/busInterface.sv
src/core.sv
testbench/coreRefModel.sv
testbench/coreTb.sv

//--- Bender.yml
package:
  name: forthCore

export_include_dirs:
  - src

sources:
  - src/isaPkg.sv
  - src/corePkg.sv
  - src/memAccessIf.sv
  - src/coreSequencer.sv
  - src/instructionDecoder.sv
  - src/registerFile.sv
  - src/loadStoreUnit.sv
  - src/busInterface.sv
  - src/core.sv
  - target: test
    files:
      - testbench/coreRefModel.sv
      - testbench/coreTb.sv
